/* logic/ifu_pkg.sv */
// Instruction fetch unit shared types
// Address, word and parcel types, memory FSM states, default parameters
package ifu_pkg;

   // ************************************************************************
   // Data types
   // ************************************************************************

   typedef logic [31:1] pc_t;                  // Halfword-granular address
   typedef logic [31:0] word_t;                // One memory word
   typedef logic [15:0] half_t;                // One instruction parcel

   // Four-phase memory handshake states
   typedef enum logic [1:0] {
      MEM_IDLE         = 2'b00,                // Ready for a new request
      MEM_WAIT_ACK     = 2'b01,                // Req high, waiting for ack
      MEM_WAIT_RELEASE = 2'b10                 // Req dropped, waiting for ack low
   } mem_state_t;

   // ************************************************************************
   // Default configuration
   // ************************************************************************

   // Fetch start after reset
   localparam logic [31:0] DEFAULT_RESET_VEC = 32'h0000_0000;

   // 16 BTB entries
   localparam int DEFAULT_BTB_INDEX_BITS = 4;

   // Partial tag kept per BTB entry
   localparam int DEFAULT_BTB_TAG_BITS = 8;

endpackage

/* logic/ifu_fetch_ctl.sv */
// Fetch controller
// Holds the fetch address, picks the next one and issues fetch requests
module ifu_fetch_ctl
   import ifu_pkg::*;
#(
   parameter logic [31:0] RESET_VEC = DEFAULT_RESET_VEC   // First fetch address
) (
   input  logic clk,
   input  logic rst_n,                         // Sync reset, active low

   input  logic exu_flush_final,               // Redirect from execute
   input  pc_t  exu_flush_path_final,          // Redirect target

   input  logic mem_idle,                      // Memory controller can start
   input  logic fb_ready,                      // Aligner has room for a word

   input  logic btb_hit,                       // BTB has taken target for word
   input  pc_t  btb_target,                    // Predicted target
   input  logic dec_tlu_bpred_disable,         // Ignore BTB

   output pc_t  btb_rd_addr,                   // BTB lookup address
   output logic fetch_go,                      // One-cycle fetch start
   output pc_t  fetch_addr,                    // Address of the fetch
   output logic fetch_pred_taken               // Word ends in predicted-taken
);

   pc_t  fetch_addr_q;                         // Next address to fetch
   pc_t  seq_addr;                             // Next word boundary
   pc_t  next_addr;
   logic pred_taken;

   // ************************************************************************
   // Next address selection
   // ************************************************************************

   assign btb_rd_addr = fetch_addr_q;          // Lookup runs on current fetch
   assign pred_taken  = btb_hit & ~dec_tlu_bpred_disable;

   // Step to the following word, upper-half entry drops to lower half
   assign seq_addr = {fetch_addr_q[31:2] + 30'd1, 1'b0};

   always_comb begin
      next_addr = fetch_addr_q;                // Hold by default
      if (exu_flush_final) begin
         next_addr = exu_flush_path_final;     // Flush wins over everything
      end else if (fetch_go) begin
         if (pred_taken) begin
            next_addr = btb_target;            // Follow the prediction
         end else begin
            next_addr = seq_addr;
         end
      end
   end

   // ************************************************************************
   // Request issue
   // ************************************************************************

   // Only one word in flight, and only when the buffer can take it
   assign fetch_go         = mem_idle & fb_ready & ~exu_flush_final;
   assign fetch_addr       = fetch_addr_q;
   assign fetch_pred_taken = pred_taken;       // Travels with the request

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         fetch_addr_q <= RESET_VEC[31:1];      // Start at reset vector
      end else begin
         fetch_addr_q <= next_addr;
      end
   end

endmodule

/* logic/ifu_btb.sv */
// Branch target buffer, direct mapped
// Predicts a taken target per fetch word, trained by execute mispredicts
module ifu_btb
   import ifu_pkg::*;
#(
   parameter int BTB_INDEX_BITS = DEFAULT_BTB_INDEX_BITS,  // log2 of entries
   parameter int BTB_TAG_BITS   = DEFAULT_BTB_TAG_BITS     // Partial tag width
) (
   input  logic clk,
   input  logic rst_n,                         // Sync reset, active low

   // Lookup port
   input  pc_t  btb_rd_addr,                   // Current fetch address
   output logic btb_hit,                       // Valid entry, tag match
   output pc_t  btb_target,                    // Stored target

   // Mispredict update port
   input  logic mp_valid,                      // Update strobe
   input  pc_t  mp_pc,                         // Branch address
   input  logic mp_taken,                      // Actual direction
   input  pc_t  mp_target                      // Actual target
);

   localparam int ENTRIES = 1 << BTB_INDEX_BITS;
   localparam int IDX_LO  = 2;                          // Word address bits
   localparam int IDX_HI  = IDX_LO + BTB_INDEX_BITS - 1;
   localparam int TAG_LO  = IDX_HI + 1;
   localparam int TAG_HI  = TAG_LO + BTB_TAG_BITS - 1;

   logic [ENTRIES-1:0]      valid_q;           // One valid bit per entry
   logic [BTB_TAG_BITS-1:0] tag_q [ENTRIES];   // Partial tags
   pc_t                     target_q [ENTRIES];

   logic [BTB_INDEX_BITS-1:0] rd_idx;
   logic [BTB_TAG_BITS-1:0]   rd_tag;
   logic [BTB_INDEX_BITS-1:0] wr_idx;
   logic [BTB_TAG_BITS-1:0]   wr_tag;
   logic                      wr_set;          // Install taken branch
   logic                      wr_clr;          // Drop not-taken branch

   // ************************************************************************
   // Lookup
   // ************************************************************************

   assign rd_idx = btb_rd_addr[IDX_HI:IDX_LO];
   assign rd_tag = btb_rd_addr[TAG_HI:TAG_LO];

   assign btb_hit    = valid_q[rd_idx] & (tag_q[rd_idx] == rd_tag);
   assign btb_target = target_q[rd_idx];

   // ************************************************************************
   // Update
   // ************************************************************************

   assign wr_idx = mp_pc[IDX_HI:IDX_LO];       // Word holding the branch
   assign wr_tag = mp_pc[TAG_HI:TAG_LO];

   assign wr_set = mp_valid & mp_taken;
   // Clear only the entry that actually belongs to this branch word
   assign wr_clr = mp_valid & ~mp_taken & valid_q[wr_idx] & (tag_q[wr_idx] == wr_tag);

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         valid_q <= '0;                        // Empty after reset
      end else if (wr_set) begin
         valid_q[wr_idx] <= 1'b1;
      end else if (wr_clr) begin
         valid_q[wr_idx] <= 1'b0;
      end
   end

   // Tag and target storage
   always_ff @(posedge clk) begin
      if (wr_set) begin
         tag_q[wr_idx]    <= wr_tag;
         target_q[wr_idx] <= mp_target;
      end
   end

endmodule

/* logic/ifu_mem_ctl.sv */
// Memory controller
// Fetches one 32-bit word per four-phase req/ack handshake
// A flush retires the word in flight without delivering it
module ifu_mem_ctl
   import ifu_pkg::*;
(
   input  logic  clk,
   input  logic  rst_n,                        // Sync reset, active low

   // From fetch controller
   input  logic  fetch_go,                     // Start a word fetch
   input  pc_t   fetch_addr,                   // Halfword address of fetch
   input  logic  fetch_pred_taken,             // BTB prediction for the word
   input  logic  exu_flush_final,              // Redirect, current word stale
   output logic  mem_idle,                     // Ready for next fetch_go

   // External instruction memory
   output logic  mem_req,
   output pc_t   mem_addr,                     // Word address, bit 1 zero
   input  logic  mem_ack,
   input  word_t mem_rdata,

   // To aligner
   output logic  word_valid,                   // One-cycle delivery pulse
   output word_t word_data,
   output pc_t   word_pc,                      // First parcel to use
   output logic  word_pred_taken
);

   mem_state_t state_q;
   mem_state_t state_d;
   pc_t        addr_q;                         // Request address
   logic       pred_q;                         // Request prediction
   logic       stale_q;                        // Flushed while in flight
   logic       ack_seen;                       // Data valid this cycle

   // ************************************************************************
   // Handshake FSM
   // ************************************************************************

   assign ack_seen = (state_q == MEM_WAIT_ACK) & mem_ack;

   always_comb begin
      state_d = state_q;
      case (state_q)
         MEM_IDLE: begin
            if (fetch_go)
               state_d = MEM_WAIT_ACK;         // Req rises next cycle
         end
         MEM_WAIT_ACK: begin
            if (mem_ack)
               state_d = MEM_WAIT_RELEASE;     // Capture and drop req
         end
         MEM_WAIT_RELEASE: begin
            if (!mem_ack)
               state_d = MEM_IDLE;             // Handshake complete
         end
         default: state_d = MEM_IDLE;
      endcase
   end

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         state_q    <= MEM_IDLE;
         stale_q    <= 1'b0;
         word_valid <= 1'b0;
      end else begin
         state_q    <= state_d;
         word_valid <= ack_seen & ~stale_q & ~exu_flush_final;
         if (state_q == MEM_IDLE) begin
            stale_q <= 1'b0;                   // New transaction starts clean
         end else if (exu_flush_final) begin
            stale_q <= 1'b1;
         end
      end
   end

   // ************************************************************************
   // Request and data registers
   // ************************************************************************

   always_ff @(posedge clk) begin
      if (fetch_go) begin
         addr_q <= fetch_addr;
         pred_q <= fetch_pred_taken;
      end
      if (ack_seen) begin
         word_data       <= mem_rdata;
         word_pc         <= addr_q;            // Bit 1 marks upper-half entry
         word_pred_taken <= pred_q;
      end
   end

   assign mem_req  = (state_q == MEM_WAIT_ACK);
   assign mem_addr = {addr_q[31:2], 1'b0};     // Stable for whole request
   assign mem_idle = (state_q == MEM_IDLE);

endmodule

/* logic/ifu_aligner.sv */
// Instruction aligner
// Queues fetched parcels and hands one 16- or 32-bit instruction to decode
module ifu_aligner
   import ifu_pkg::*;
(
   input  logic  clk,
   input  logic  rst_n,                        // Sync reset, active low

   // From memory controller
   input  logic  word_valid,
   input  word_t word_data,
   input  pc_t   word_pc,                      // Bit 1 set drops lower parcel
   input  logic  word_pred_taken,

   input  logic  exu_flush_final,              // Empty the queue
   input  logic  dec_i0_decode_d,              // Decode takes instruction
   output logic  fb_ready,                     // Two or more free slots

   // To decode
   output logic  i0_valid,
   output word_t i0_instr,
   output pc_t   i0_pc,
   output logic  i0_pc4,                       // 32-bit instruction
   output logic  i0_pred_taken
);

   localparam int SLOTS = 4;

   half_t      data_q [SLOTS];                 // Parcel queue, slot 0 is head
   half_t      data_d [SLOTS];
   pc_t        pc_q   [SLOTS];
   pc_t        pc_d   [SLOTS];
   logic [3:0] flag_q;                         // Last parcel of taken word
   logic [3:0] flag_d;
   logic [2:0] count_q;                        // Parcels held, 0 to 4
   logic [2:0] count_d;
   logic [2:0] count_pop;                      // Count after the pop

   half_t      push_data [2];
   pc_t        push_pc   [2];
   logic [1:0] push_flag;
   logic [1:0] n_push;                         // Parcels in delivered word
   logic [1:0] n_pop;                          // Parcels consumed
   logic       is32;                           // Head starts 32-bit instr

   // ************************************************************************
   // Head decode
   // ************************************************************************

   assign is32 = (data_q[0][1:0] == 2'b11);

   // A 32-bit instruction needs both its parcels present
   assign i0_valid      = (count_q != 3'd0) & (~is32 | (count_q >= 3'd2));
   assign i0_instr      = is32 ? {data_q[1], data_q[0]} : {16'h0000, data_q[0]};
   assign i0_pc         = pc_q[0];
   assign i0_pc4        = is32;
   assign i0_pred_taken = is32 ? flag_q[1] : flag_q[0];  // Flag on last parcel

   assign n_pop    = (i0_valid & dec_i0_decode_d) ? (is32 ? 2'd2 : 2'd1) : 2'd0;
   assign fb_ready = (count_q <= 3'd2);

   // ************************************************************************
   // Incoming word split
   // ************************************************************************

   assign n_push       = word_pc[1] ? 2'd1 : 2'd2;
   assign push_data[0] = word_pc[1] ? word_data[31:16] : word_data[15:0];
   assign push_data[1] = word_data[31:16];
   assign push_pc[0]   = word_pc;              // First usable parcel
   assign push_pc[1]   = {word_pc[31:2], 1'b1};
   assign push_flag[0] = word_pc[1] & word_pred_taken;  // Sole parcel ends word
   assign push_flag[1] = word_pred_taken;

   // ************************************************************************
   // Queue update, pop then append
   // ************************************************************************

   always_comb begin
      count_pop = count_q - 3'(n_pop);
      for (int i = 0; i < SLOTS; i++) begin
         data_d[i] = data_q[i];
         pc_d[i]   = pc_q[i];
         flag_d[i] = flag_q[i];
         if (i + int'(n_pop) < SLOTS) begin    // Shift toward head
            data_d[i] = data_q[i + int'(n_pop)];
            pc_d[i]   = pc_q[i + int'(n_pop)];
            flag_d[i] = flag_q[i + int'(n_pop)];
         end
      end
      for (int j = 0; j < 2; j++) begin
         if (word_valid && (j < int'(n_push)) && (int'(count_pop) + j < SLOTS)) begin
            data_d[int'(count_pop) + j] = push_data[j];
            pc_d[int'(count_pop) + j]   = push_pc[j];
            flag_d[int'(count_pop) + j] = push_flag[j];
         end
      end
      count_d = count_pop + (word_valid ? 3'(n_push) : 3'd0);
   end

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         count_q <= 3'd0;
      end else if (exu_flush_final) begin
         count_q <= 3'd0;                      // Drops old stream and any arrival
      end else begin
         count_q <= count_d;
      end
   end

   // Parcel payload
   always_ff @(posedge clk) begin
      data_q <= data_d;
      pc_q   <= pc_d;
      flag_q <= flag_d;
   end

endmodule

/* logic/ifu_top.sv */
// Instruction fetch unit top level
// Fetch control, BTB, memory controller and aligner
module ifu_top
   import ifu_pkg::*;
#(
   parameter logic [31:0] RESET_VEC      = DEFAULT_RESET_VEC,
   parameter int          BTB_INDEX_BITS = DEFAULT_BTB_INDEX_BITS,
   parameter int          BTB_TAG_BITS   = DEFAULT_BTB_TAG_BITS
) (
   input  logic  clk,
   input  logic  rst_n,                        // Sync reset, active low

   input  logic  dec_i0_decode_d,              // Decode consumes i0
   input  logic  exu_flush_final,              // Redirect strobe
   input  pc_t   exu_flush_path_final,         // Redirect address
   input  logic  dec_tlu_bpred_disable,        // Turn off prediction

   // Mispredict update from execute
   input  logic  mp_valid,
   input  pc_t   mp_pc,
   input  logic  mp_taken,
   input  pc_t   mp_target,

   // Instruction memory, four-phase
   output logic  mem_req,
   output pc_t   mem_addr,
   input  logic  mem_ack,
   input  word_t mem_rdata,

   // To decode
   output logic  i0_valid,
   output word_t i0_instr,
   output pc_t   i0_pc,
   output logic  i0_pc4,
   output logic  i0_pred_taken
);

   pc_t   btb_rd_addr;
   logic  btb_hit;
   pc_t   btb_target;
   logic  fetch_go;
   pc_t   fetch_addr;
   logic  fetch_pred_taken;
   logic  mem_idle;
   logic  fb_ready;
   logic  word_valid;
   word_t word_data;
   pc_t   word_pc;
   logic  word_pred_taken;

   // ************************************************************************
   // Fetch address and prediction
   // ************************************************************************

   ifu_fetch_ctl #(.RESET_VEC(RESET_VEC)) fetch_ctl (
      .clk, .rst_n, .exu_flush_final, .exu_flush_path_final, .mem_idle, .fb_ready,
      .btb_hit, .btb_target, .dec_tlu_bpred_disable, .btb_rd_addr, .fetch_go,
      .fetch_addr, .fetch_pred_taken
   );

   ifu_btb #(.BTB_INDEX_BITS(BTB_INDEX_BITS), .BTB_TAG_BITS(BTB_TAG_BITS)) btb (
      .clk, .rst_n, .btb_rd_addr, .btb_hit, .btb_target,
      .mp_valid, .mp_pc, .mp_taken, .mp_target
   );

   // ************************************************************************
   // Memory access and alignment
   // ************************************************************************

   ifu_mem_ctl mem_ctl (
      .clk, .rst_n, .fetch_go, .fetch_addr, .fetch_pred_taken, .exu_flush_final,
      .mem_idle, .mem_req, .mem_addr, .mem_ack, .mem_rdata,
      .word_valid, .word_data, .word_pc, .word_pred_taken
   );

   ifu_aligner aligner (
      .clk, .rst_n, .word_valid, .word_data, .word_pc, .word_pred_taken,
      .exu_flush_final, .dec_i0_decode_d, .fb_ready,
      .i0_valid, .i0_instr, .i0_pc, .i0_pc4, .i0_pred_taken
   );

endmodule

/* test/tb_ifu.sv */
// Testbench for the instruction fetch unit
// Four-phase memory model, instruction stream reference and directed tests
module tb_ifu
   import ifu_pkg::*;
;
   timeunit 1ns;
   timeprecision 100ps;

   logic  clk = 1'b0;
   logic  rst_n;
   logic  dec_i0_decode_d;
   logic  exu_flush_final;
   pc_t   exu_flush_path_final;
   logic  dec_tlu_bpred_disable;
   logic  mp_valid;
   pc_t   mp_pc;
   logic  mp_taken;
   pc_t   mp_target;
   logic  mem_req;
   pc_t   mem_addr;
   logic  mem_ack;
   word_t mem_rdata;
   logic  i0_valid;
   word_t i0_instr;
   pc_t   i0_pc;
   logic  i0_pc4;
   logic  i0_pred_taken;

   word_t       mem_image [256];               // 1 KB instruction memory
   logic        btb_set = 1'b0;                // Model of trained BTB entry
   logic [29:0] btb_word;                      // Word holding the branch
   logic [31:0] btb_tgt;                       // Byte target
   logic        pred_on = 1'b1;                // Prediction enabled

   ifu_top dut (
      .clk(clk), .rst_n(rst_n), .dec_i0_decode_d(dec_i0_decode_d),
      .exu_flush_final(exu_flush_final), .exu_flush_path_final(exu_flush_path_final),
      .dec_tlu_bpred_disable(dec_tlu_bpred_disable), .mp_valid(mp_valid), .mp_pc(mp_pc),
      .mp_taken(mp_taken), .mp_target(mp_target), .mem_req(mem_req), .mem_addr(mem_addr),
      .mem_ack(mem_ack), .mem_rdata(mem_rdata), .i0_valid(i0_valid), .i0_instr(i0_instr),
      .i0_pc(i0_pc), .i0_pc4(i0_pc4), .i0_pred_taken(i0_pred_taken)
   );

   always #2 clk = ~clk;                       // 4 ns period

   // ************************************************************************
   // Helpers
   // ************************************************************************

   function automatic logic [31:0] xorshift(input logic [31:0] s);
      logic [31:0] x;
      x = s;
      x = x ^ (x << 13);
      x = x ^ (x >> 17);
      x = x ^ (x << 5);
      return x;
   endfunction

   task automatic fail_run(input string msg);
      $display("%s", msg);
      $display("TB FAILED");
      $fatal(1, "stopped at first error");
   endtask

   task automatic check_equal(input string what, input logic [31:0] got,
                              input logic [31:0] exp);
      if (got !== exp)
         fail_run($sformatf("Error at %0t ns: %s is %h, expected %h", $time, what, got, exp));
   endtask

   task automatic drive_point();
      @(posedge clk);
      #1;                                      // Inputs change after the edge
   endtask

   task automatic put_parcel(input logic [31:0] a, input logic [15:0] h);
      if (a[1])
         mem_image[a[9:2]][31:16] = h;
      else
         mem_image[a[9:2]][15:0] = h;
   endtask

   function automatic logic [15:0] parcel_at(input logic [31:0] a);
      word_t w;
      w = mem_image[a[9:2]];
      return a[1] ? w[31:16] : w[15:0];
   endfunction

   // Bit k of lens set makes instruction k a 32-bit one
   task automatic lay_program(input logic [31:0] start, input int n, input logic [31:0] lens);
      logic [31:0] a;
      logic [31:0] ins;
      a = start;
      for (int k = 0; k < n; k++) begin
         if (lens[k]) begin
            ins = {8'h5a, a[21:0], 2'b11};
            put_parcel(a, ins[15:0]);
            put_parcel(a + 32'd2, ins[31:16]);
            a = a + 32'd4;
         end else begin
            ins = {16'h0000, a[11:1], 3'b100, 2'b10};
            put_parcel(a, ins[15:0]);
            a = a + 32'd2;
         end
      end
   endtask

   task automatic wait_instr();
      int cycles;
      cycles = 0;
      @(negedge clk);
      while (!i0_valid) begin
         cycles++;
         if (cycles > 100)
            fail_run($sformatf("Timeout at %0t ns waiting for an instruction at decode", $time));
         @(negedge clk);
      end
   endtask

   // Reference walk of the image, one check per instruction consumed
   task automatic expect_stream(input logic [31:0] start, input int n);
      logic [31:0] a;
      logic [31:0] last;
      logic [15:0] lo;
      logic [31:0] exp_instr;
      logic        exp_pc4;
      logic        exp_pred;
      a = start;
      for (int k = 0; k < n; k++) begin
         lo        = parcel_at(a);
         exp_pc4   = (lo[1:0] == 2'b11);
         exp_instr = exp_pc4 ? {parcel_at(a + 32'd2), lo} : {16'h0000, lo};
         last      = exp_pc4 ? a + 32'd2 : a;
         exp_pred  = pred_on & btb_set & (last[31:2] == btb_word) & last[1];
         wait_instr();                         // Sampled at negedge, taken at next edge
         check_equal("i0_pc", {i0_pc, 1'b0}, a);
         check_equal("i0_instr", i0_instr, exp_instr);
         check_equal("i0_pc4", i0_pc4, exp_pc4);
         check_equal("i0_pred_taken", i0_pred_taken, exp_pred);
         a = exp_pred ? btb_tgt : a + (exp_pc4 ? 32'd4 : 32'd2);
      end
   endtask

   task automatic flush_to(input logic [31:0] a);
      drive_point();
      exu_flush_final      = 1'b1;
      exu_flush_path_final = a[31:1];
      drive_point();
      exu_flush_final      = 1'b0;
   endtask

   task automatic train_taken(input logic [31:0] branch, input logic [31:0] target);
      drive_point();
      mp_valid  = 1'b1;
      mp_pc     = branch[31:1];
      mp_taken  = 1'b1;
      mp_target = target[31:1];
      drive_point();
      mp_valid  = 1'b0;
      btb_set   = 1'b1;                        // Mirror the training in the model
      btb_word  = branch[31:2];
      btb_tgt   = target;
   endtask

   // ************************************************************************
   // Memory responder, four-phase req/ack
   // ************************************************************************

   initial begin : memory_responder
      logic [31:0] rng;
      pc_t         addr;
      int          cycles;
      mem_ack   = 1'b0;
      mem_rdata = '0;
      rng       = 32'h5ccc;
      forever begin
         @(negedge clk);
         if (mem_req === 1'b1) begin
            addr = mem_addr;
            rng  = xorshift(rng);
            repeat (rng[1:0]) @(negedge clk);  // 0 to 3 cycles of latency
            drive_point();
            mem_rdata = mem_image[addr[9:2]];
            mem_ack   = 1'b1;
            cycles    = 0;
            do begin
               @(negedge clk);
               cycles++;
               if (cycles > 50)
                  fail_run("Timeout: the DUT never dropped mem_req after mem_ack");
            end while (mem_req);
            drive_point();
            mem_ack = 1'b0;
         end
      end
   end

   // ************************************************************************
   // Directed tests
   // ************************************************************************

   task automatic check_reset_state();
      int cycles;
      repeat (3) begin
         @(negedge clk);
         check_equal("mem_req in reset", mem_req, 1'b0);
         check_equal("i0_valid in reset", i0_valid, 1'b0);
      end
      drive_point();
      rst_n = 1'b1;                            // Four reset edges seen
      @(negedge clk);
      check_equal("mem_req after reset", mem_req, 1'b0);
      check_equal("i0_valid after reset", i0_valid, 1'b0);
      cycles = 0;
      while (mem_req !== 1'b1) begin
         cycles++;
         if (cycles > 20)
            fail_run("Timeout: no memory request after reset");
         @(negedge clk);
      end
      check_equal("first mem_addr", {mem_addr, 1'b0}, DEFAULT_RESET_VEC);
   endtask

   task automatic sequential_fetch();
      drive_point();
      dec_i0_decode_d = 1'b1;
      expect_stream(DEFAULT_RESET_VEC, 8);
   endtask

   task automatic mixed_lengths();
      expect_stream(32'h20, 12);               // Continues straight after the 32-bit run
   endtask

   task automatic flush_redirect();
      flush_to(32'hc2);                        // Odd halfword, lower parcel dropped
      expect_stream(32'hc2, 8);
   endtask

   task automatic branch_prediction();
      train_taken(32'h104, 32'h182);
      flush_to(32'h100);
      expect_stream(32'h100, 8);
      drive_point();
      dec_tlu_bpred_disable = 1'b1;
      pred_on               = 1'b0;
      flush_to(32'h100);
      expect_stream(32'h100, 6);
      drive_point();
      dec_tlu_bpred_disable = 1'b0;
      pred_on               = 1'b1;
   endtask

   task automatic back_pressure();
      int quiet;
      int cycles;
      drive_point();
      dec_i0_decode_d = 1'b0;
      flush_to(32'h200);
      quiet  = 0;
      cycles = 0;
      while (quiet < 20) begin
         @(negedge clk);
         cycles++;
         quiet = mem_req ? 0 : quiet + 1;
         if (cycles > 300)
            fail_run("Timeout: memory requests did not stop while decode was stalled");
      end
      check_equal("i0_valid while stalled", i0_valid, 1'b1);
      drive_point();
      dec_i0_decode_d = 1'b1;
      expect_stream(32'h200, 14);
   endtask

   initial begin
      rst_n                 = 1'b0;
      dec_i0_decode_d       = 1'b0;            // Hold the stream until test 2
      exu_flush_final       = 1'b0;
      exu_flush_path_final  = '0;
      dec_tlu_bpred_disable = 1'b0;
      mp_valid              = 1'b0;
      mp_pc                 = '0;
      mp_taken              = 1'b0;
      mp_target             = '0;
      for (int i = 0; i < 256; i++) begin
         mem_image[i] = {i[7:0], 8'h02, i[7:0], 8'h01};  // Compressed filler
      end
      lay_program(32'h000, 8, 32'hff);
      lay_program(32'h020, 12, 32'h2b2);       // Several word crossings
      lay_program(32'h0c2, 8, 32'h5a);
      lay_program(32'h100, 6, 32'h0b);         // Branch word ends at 0x106
      lay_program(32'h182, 6, 32'h15);
      lay_program(32'h200, 14, 32'h12b2);

      check_reset_state();
      sequential_fetch();
      mixed_lengths();
      flush_redirect();
      branch_prediction();
      back_pressure();

      $display("TB PASSED");
      $finish;
   end

endmodule

/* tb.f */
logic/ifu_pkg.sv
logic/ifu_fetch_ctl.sv
logic/ifu_btb.sv
logic/ifu_mem_ctl.sv
logic/ifu_aligner.sv
logic/ifu_top.sv
test/tb_ifu.sv
